/* logic/lshape_buffer.sv */
`default_nettype none

`include "lshape_macros.svh"

module lshape_buffer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        us_valid,
  input  lshape_data_pkg::side_t      us_side,
  output logic                        us_stall,
  input  lshape_data_pkg::unstall_t   us_unstall,
  input  logic                        rdreq,
  output logic                        empty,
  output lshape_data_pkg::fifo_word_t ds_data
);

  logic                        ds_valid;
  lshape_data_pkg::side_t      ds_side;
  lshape_data_pkg::fifo_word_t fifo_wdata;
  lshape_ctrl_pkg::slot_cnt_t  free_slots;

  pipe_valid_stall #(
    .WIDTH(`LS_SIDE_W),
    .DEPTH(`LS_PIPE_DEPTH)
  ) pipe_inst (
    .clk        (clk),
    .rst        (rst),
    .us_valid   (us_valid),
    .us_side    (us_side),
    .us_stall   (us_stall),
    .ds_valid   (ds_valid),
    .ds_side    (ds_side),
    .free_slots (free_slots)
  );

  // the unstall half is taken in the same cycle the side item leaves the pipeline
  always_comb begin
    fifo_wdata.side    = ds_side;
    fifo_wdata.unstall = us_unstall;
  end

  side_fifo #(
    .DEPTH(`LS_FIFO_DEPTH)
  ) fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .we         (ds_valid),
    .wdata      (fifo_wdata),
    .re         (rdreq),
    .rdata      (ds_data),
    .empty      (empty),
    .full       (),
    .free_slots (free_slots)
  );

endmodule

`default_nettype wire

/* logic/lshape_ctrl_pkg.sv */
`default_nettype none

`include "lshape_macros.svh"

package lshape_ctrl_pkg;

  localparam int INFLIGHT_W = $clog2(`LS_PIPE_DEPTH + 1);
  localparam int SLOT_W     = $clog2(`LS_FIFO_DEPTH + 1);

  // holds 0 up to LS_PIPE_DEPTH items in the pipeline
  typedef logic [INFLIGHT_W-1:0] inflight_cnt_t;

  typedef logic [SLOT_W-1:0] slot_cnt_t;  // 0 up to LS_FIFO_DEPTH free entries

endpackage

`default_nettype wire

/* logic/lshape_data_pkg.sv */
`default_nettype none

`include "lshape_macros.svh"

package lshape_data_pkg;

  // data that travels through the fixed-latency pipeline
  typedef logic [`LS_SIDE_W-1:0] side_t;

  // data that arrives from outside in the exit cycle
  typedef logic [`LS_UNSTALL_W-1:0] unstall_t;

  // one fifo entry with the side data in the upper bits
  typedef struct packed {
    side_t    side;
    unstall_t unstall;
  } fifo_word_t;

endpackage

`default_nettype wire

/* logic/lshape_macros.svh */
`ifndef LSHAPE_MACROS_SVH
`define LSHAPE_MACROS_SVH

// payload widths of the two inputs that meet at the fifo
`define LS_SIDE_W 8
`define LS_UNSTALL_W 16

// latency of the side pipeline in clock cycles
`define LS_PIPE_DEPTH 4

// the fifo works with any number of entries from one up
`define LS_FIFO_DEPTH 8

`endif

/* logic/pipe_valid_stall.sv */
`default_nettype none

`include "lshape_macros.svh"

module pipe_valid_stall #(
  parameter int WIDTH = `LS_SIDE_W,
  parameter int DEPTH = `LS_PIPE_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       us_valid,
  input  lshape_data_pkg::side_t     us_side,
  output logic                       us_stall,
  output logic                       ds_valid,
  output lshape_data_pkg::side_t     ds_side,
  input  lshape_ctrl_pkg::slot_cnt_t free_slots
);

  logic                           accept;
  logic [DEPTH-1:0]               valid_q;
  logic [WIDTH-1:0]               data_q [DEPTH];
  lshape_ctrl_pkg::inflight_cnt_t inflight_q;

  if (WIDTH != $bits(lshape_data_pkg::side_t)) begin : g_width_check
    $error("pipe_valid_stall: WIDTH does not match side_t");
  end

  if (DEPTH < 1 || $clog2(DEPTH + 1) > $bits(lshape_ctrl_pkg::inflight_cnt_t))
  begin : g_depth_check
    $error("pipe_valid_stall: DEPTH does not fit inflight_cnt_t");
  end

  assign accept = us_valid & ~us_stall;

  // stage 0 takes the accepted item and stage DEPTH-1 feeds the fifo
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= accept;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // data moves every cycle alongside its valid bit
  always_ff @(posedge clk) begin
    data_q[0] <= us_side;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign ds_valid = valid_q[DEPTH-1];
  assign ds_side  = data_q[DEPTH-1];

  // an entry and an exit in the same cycle leave the count unchanged
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      inflight_q <= '0;
    end else if (accept && !ds_valid) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (!accept && ds_valid) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  // every item in flight already owns one free fifo slot
  assign us_stall = 32'(inflight_q) >= 32'(free_slots);

  // the count follows the valid bits, so exceeding the stage count means entries and
  // exits went out of step with the shift
  a_inflight_bound: assert property (
    @(posedge clk) disable iff (rst) 32'(inflight_q) <= DEPTH
  ) else $error("pipe_valid_stall: in-flight count %0d above depth", inflight_q);

endmodule

`default_nettype wire

/* logic/side_fifo.sv */
`default_nettype none

`include "lshape_macros.svh"

module side_fifo #(
  parameter int DEPTH = `LS_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we,
  input  lshape_data_pkg::fifo_word_t  wdata,
  input  logic                         re,
  output lshape_data_pkg::fifo_word_t  rdata,
  output logic                         empty,
  output logic                         full,
  output lshape_ctrl_pkg::slot_cnt_t   free_slots
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic                        wr_ok;
  logic                        rd_ok;
  logic [PTR_W-1:0]            wptr_q;
  logic [PTR_W-1:0]            rptr_q;
  lshape_ctrl_pkg::slot_cnt_t  used_q;
  lshape_ctrl_pkg::slot_cnt_t  free_q;
  lshape_data_pkg::fifo_word_t mem [DEPTH];

  if (DEPTH < 1 || $clog2(DEPTH + 1) > $bits(lshape_ctrl_pkg::slot_cnt_t))
  begin : g_depth_check
    $error("side_fifo: DEPTH does not fit slot_cnt_t");
  end

  assign empty = (used_q == '0);
  assign full  = (free_q == '0);

  // a read on an empty fifo and a write on a full one are dropped
  assign wr_ok = we & ~full;
  assign rd_ok = re & ~empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wptr_q] <= wdata;
    end
  end

  // the head entry is always on the output, so a new word shows up one edge after its write
  assign rdata = mem[rptr_q];

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (wr_ok) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (rd_ok) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
    end
  end

  // used and free move in opposite directions and always add up to DEPTH
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      used_q <= '0;
      free_q <= lshape_ctrl_pkg::slot_cnt_t'(DEPTH);
    end else begin
      case ({wr_ok, rd_ok})
        2'b10: begin
          used_q <= used_q + 1'b1;
          free_q <= free_q - 1'b1;
        end
        2'b01: begin
          used_q <= used_q - 1'b1;
          free_q <= free_q + 1'b1;
        end
        default: begin
          used_q <= used_q;  // idle, or a push and a pop together
          free_q <= free_q;
        end
      endcase
    end
  end

  assign free_slots = free_q;

  // the credit stall upstream is what keeps writes away from a full fifo
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) !(we && full)
  ) else $error("side_fifo: write while full, word dropped");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the lshape testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module lshape_tb \
  -f tb.f \
  -o lshape_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit $build_status
fi

if [ ! -x ./obj_dir/lshape_sim ]; then
  echo "simulation executable not found"
  exit 1
fi

./obj_dir/lshape_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit $sim_status
fi

exit 0

/* tb.f */
+incdir+logic
logic/lshape_data_pkg.sv
logic/lshape_ctrl_pkg.sv
logic/pipe_valid_stall.sv
logic/side_fifo.sv
logic/lshape_buffer.sv
verification/lshape_tb.sv

/* verification/lshape_stim.txt */
// one hex word per cycle: us_valid _ side _ unstall _ rdreq
// the word ffffffff ends the stimulus
// reads on an empty fifo
0_00_a001_1
0_00_a002_1
0_00_a003_0
// fill with no reads, item 09 is held while stalled
1_01_b000_0
1_02_b001_0
1_03_b002_0
1_04_b003_0
1_05_b004_0
1_06_b005_0
1_07_b006_0
1_08_b007_0
1_09_b008_0
1_09_b009_0
1_09_b00a_0
1_09_b00b_0
1_09_b00c_0
1_09_b00d_0
// drain in order, stall drops, then reads on empty again
1_09_c000_1
1_09_c001_1
1_0a_c002_1
1_0b_c003_1
0_00_c004_1
0_00_c005_1
0_00_c006_1
0_00_c007_1
0_00_c008_1
0_00_c009_1
0_00_c00a_1
0_00_c00b_1
0_00_c00c_1
0_00_c00d_1
// streaming with reads and writes in the same cycle
1_10_d000_0
1_11_d001_0
1_12_d002_0
1_13_d003_0
1_14_d004_0
1_15_d005_1
1_16_d006_1
1_17_d007_0
1_18_d008_1
1_19_d009_1
0_00_d00a_1
0_00_d00b_1
0_00_d00c_1
0_00_d00d_1
0_00_d00e_1
0_00_d00f_1
0_00_d010_1
0_00_d011_1
ffffffff

/* verification/lshape_tb.sv */
`default_nettype none

`include "lshape_macros.svh"

module lshape_tb;

  localparam int          STIM_MAX = 256;
  localparam logic [31:0] STIM_END = 32'hffff_ffff;

  logic                        clk;
  logic                        rst;
  logic                        us_valid;
  lshape_data_pkg::side_t      us_side;
  logic                        us_stall;
  lshape_data_pkg::unstall_t   us_unstall;
  logic                        rdreq;
  logic                        empty;
  lshape_data_pkg::fifo_word_t ds_data;

  logic [31:0] stim_mem [STIM_MAX];
  int          num_lines;
  int          cycle_count;

  // model of the pipeline stages and of the words held in the fifo
  bit                          pipe_v [`LS_PIPE_DEPTH];
  lshape_data_pkg::side_t      pipe_s [`LS_PIPE_DEPTH];
  lshape_data_pkg::fifo_word_t model_q [$];
  int                          max_occupancy;
  bit                          stall_seen;

  lshape_buffer uut (
    .clk        (clk),
    .rst        (rst),
    .us_valid   (us_valid),
    .us_side    (us_side),
    .us_stall   (us_stall),
    .us_unstall (us_unstall),
    .rdreq      (rdreq),
    .empty      (empty),
    .ds_data    (ds_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
    else abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic int model_inflight();
    int n;
    n = 0;
    for (int i = 0; i < `LS_PIPE_DEPTH; i++) begin
      if (pipe_v[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // stall once the items in flight could use up every free slot
  function automatic bit model_stall();
    return model_inflight() >= (`LS_FIFO_DEPTH - model_q.size());
  endfunction

  // stim word layout is valid nibble, side byte, unstall halfword, rdreq nibble
  task automatic drive_inputs(input logic [31:0] word);
    us_valid   = word[28];
    us_side    = word[27:20];
    us_unstall = word[19:4];
    rdreq      = word[0];
  endtask

  task automatic check_outputs();
    if (model_stall()) begin
      stall_seen = 1'b1;
    end
    compare_value("us_stall", 32'(us_stall), 32'(model_stall()));
    compare_value("empty", 32'(empty), 32'(model_q.size() == 0));
    if (model_q.size() != 0) begin
      compare_value("ds_data", 32'(ds_data), 32'(model_q[0]));  // head of the fifo
    end
  endtask

  // applies what the coming clock edge does to the pipeline and the fifo
  task automatic advance_model(input logic [31:0] word);
    bit                          accept;
    bit                          pop;
    lshape_data_pkg::fifo_word_t exit_word;
    accept = word[28] && !model_stall();
    pop    = word[0] && (model_q.size() != 0);  // a read on an empty fifo does nothing
    if (pipe_v[`LS_PIPE_DEPTH-1]) begin
      exit_word.side    = pipe_s[`LS_PIPE_DEPTH-1];
      exit_word.unstall = word[19:4];  // unstall half comes from the exit cycle
      model_q.push_back(exit_word);
    end
    if (pop) begin
      void'(model_q.pop_front());
    end
    for (int i = `LS_PIPE_DEPTH - 1; i > 0; i--) begin
      pipe_v[i] = pipe_v[i-1];
      pipe_s[i] = pipe_s[i-1];
    end
    pipe_v[0] = accept;
    pipe_s[0] = word[27:20];
    if (model_q.size() > max_occupancy) begin
      max_occupancy = model_q.size();
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= num_lines + 20) begin
      $display("timeout after %0d cycles, the stimulus did not run to its end", cycle_count);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  initial begin
    rst        = 1'b1;
    us_valid   = 1'b0;
    us_side    = '0;
    us_unstall = '0;
    rdreq      = 1'b0;
    cycle_count   = 0;
    max_occupancy = 0;
    stall_seen    = 1'b0;
    for (int i = 0; i < `LS_PIPE_DEPTH; i++) begin
      pipe_v[i] = 1'b0;
      pipe_s[i] = '0;
    end

    for (int i = 0; i < STIM_MAX; i++) begin
      stim_mem[i] = STIM_END;
    end
    $readmemh("verification/lshape_stim.txt", stim_mem);
    num_lines = 0;
    while (num_lines < STIM_MAX && stim_mem[num_lines] != STIM_END) begin
      num_lines++;
    end
    assert (num_lines > 0)
    else abort_run("no stimulus lines found in verification/lshape_stim.txt");

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    compare_value("empty", 32'(empty), 32'd1);
    compare_value("us_stall", 32'(us_stall), 32'd0);

    for (int i = 0; i < num_lines; i++) begin
      @(posedge clk);
      #1;
      drive_inputs(stim_mem[i]);
      #4;  // outputs have settled by mid cycle
      check_outputs();
      advance_model(stim_mem[i]);
    end
    @(posedge clk);
    #5;
    check_outputs();

    assert (max_occupancy == `LS_FIFO_DEPTH)
    else abort_run("the stimulus never filled the fifo to its depth");
    assert (stall_seen)
    else abort_run("us_stall was never expected high during the run");
    assert (model_q.size() == 0)
    else abort_run("words were left in the fifo at the end of the run");

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
